// File: hw/uart_pkg.sv
package uart_pkg;

    // 50 MHz at 115200 baud
    localparam int DEFAULT_CLKS_PER_BIT = 434;

    localparam int BYTE_BITS   = 8;
    localparam int FRAME_BYTES = 12; // operands A, B, C
    localparam int WORD_BYTES  = 4;

    typedef logic [BYTE_BITS-1:0]             byte_t;
    typedef logic [WORD_BYTES*BYTE_BITS-1:0]  word_t;
    // byte i sits at bits 8i+7..8i
    typedef logic [FRAME_BYTES*BYTE_BITS-1:0] frame_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP,
        TX_GAP  // one idle bit after each stop
    } tx_state_e;

endpackage

// File: hw/baud_timer.sv
`timescale 1ns/1ps

module baud_timer import uart_pkg::*; #(
    parameter int clks_per_bit = DEFAULT_CLKS_PER_BIT
) (
    input  logic CLK_I,
    input  logic RSTL_I,
    input  logic restart,
    output logic mid_bit,
    output logic end_bit
);

    localparam int cnt_w = $clog2(clks_per_bit);

    logic [cnt_w-1:0] cnt;

    assign end_bit = (cnt == cnt_w'(clks_per_bit - 1));
    assign mid_bit = (cnt == cnt_w'(clks_per_bit / 2));

    always_ff @(posedge CLK_I or negedge RSTL_I) begin
        if (!RSTL_I) begin
            cnt <= '0;
        end else if (restart || end_bit) begin
            cnt <= '0; // wrap at the bit boundary
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// File: hw/uart_byte_rx.sv
`timescale 1ns/1ps

module uart_byte_rx import uart_pkg::*; #(
    parameter int clks_per_bit = DEFAULT_CLKS_PER_BIT
) (
    input  logic  CLK_I,
    input  logic  RSTL_I,
    input  logic  uart_rx,
    output logic  byte_valid,
    output byte_t rx_byte
);

    localparam int bit_w = $clog2(BYTE_BITS);

    rx_state_e        state;
    logic             rx_q;
    logic [bit_w-1:0] bit_idx;
    logic             restart;
    logic             mid_bit;

    // timer starts fresh on the falling edge seen in idle
    assign restart = (state == RX_IDLE) && !rx_q;

    baud_timer #(
        .clks_per_bit(clks_per_bit)
    ) i_baud_timer (
        .CLK_I   (CLK_I),
        .RSTL_I  (RSTL_I),
        .restart (restart),
        .mid_bit (mid_bit),
        .end_bit ()
    );

    always_ff @(posedge CLK_I or negedge RSTL_I) begin
        if (!RSTL_I) begin
            rx_q <= 1'b1; // line idles high
        end else begin
            rx_q <= uart_rx;
        end
    end

    always_ff @(posedge CLK_I or negedge RSTL_I) begin
        if (!RSTL_I) begin
            state      <= RX_IDLE;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (restart) state <= RX_START;
                end
                RX_START: begin
                    if (mid_bit) begin
                        bit_idx <= '0;
                        // glitch if the line is back high already
                        state   <= rx_q ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (mid_bit) begin
                        if (bit_idx == bit_w'(BYTE_BITS - 1)) begin
                            state <= RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                RX_STOP: begin
                    if (mid_bit) begin
                        byte_valid <= 1'b1; // stop level not checked
                        state      <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // lsb first, so shift in from the top
    always_ff @(posedge CLK_I) begin
        if (state == RX_DATA && mid_bit) begin
            rx_byte <= {rx_q, rx_byte[BYTE_BITS-1:1]};
        end
    end

endmodule

// File: hw/frame_assembler.sv
`timescale 1ns/1ps

module frame_assembler import uart_pkg::*; (
    input  logic   CLK_I,
    input  logic   RSTL_I,
    input  logic   byte_valid,
    input  byte_t  rx_byte,
    output logic   frame_valid,
    output frame_t frame
);

    localparam int cnt_w = $clog2(FRAME_BYTES);

    logic [cnt_w-1:0] byte_count;
    logic             last_byte;
    frame_t           work;
    frame_t           work_next;

    assign last_byte = (byte_count == cnt_w'(FRAME_BYTES - 1));

    always_comb begin
        work_next = work;
        work_next[int'(byte_count) * BYTE_BITS +: BYTE_BITS] = rx_byte;
    end

    always_ff @(posedge CLK_I) begin
        if (byte_valid) work <= work_next;
    end

    always_ff @(posedge CLK_I or negedge RSTL_I) begin
        if (!RSTL_I) begin
            byte_count  <= '0;
            frame_valid <= 1'b0;
            frame       <= '0;
        end else begin
            frame_valid <= byte_valid && last_byte;
            if (byte_valid) begin
                if (last_byte) begin
                    byte_count <= '0;
                    frame      <= work_next; // includes byte 11
                end else begin
                    byte_count <= byte_count + 1'b1;
                end
            end
        end
    end

endmodule

// File: hw/uart_word_tx.sv
`timescale 1ns/1ps

module uart_word_tx import uart_pkg::*; #(
    parameter int clks_per_bit = DEFAULT_CLKS_PER_BIT
) (
    input  logic  CLK_I,
    input  logic  RSTL_I,
    input  logic  frame_valid,
    input  word_t tx_word,
    output logic  uart_tx
);

    localparam int bit_w  = $clog2(BYTE_BITS);
    localparam int byte_w = $clog2(WORD_BYTES);

    tx_state_e         state;
    word_t             word_q;
    logic [bit_w-1:0]  bit_idx;
    logic [byte_w-1:0] byte_idx;
    logic              restart;
    logic              end_bit;

    // frames arriving while busy are dropped
    assign restart = (state == TX_IDLE) && frame_valid;

    baud_timer #(
        .clks_per_bit(clks_per_bit)
    ) i_baud_timer (
        .CLK_I   (CLK_I),
        .RSTL_I  (RSTL_I),
        .restart (restart),
        .mid_bit (),
        .end_bit (end_bit)
    );

    always_ff @(posedge CLK_I or negedge RSTL_I) begin
        if (!RSTL_I) begin
            state    <= TX_IDLE;
            bit_idx  <= '0;
            byte_idx <= '0;
            uart_tx  <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (restart) begin
                        byte_idx <= '0;
                        uart_tx  <= 1'b0; // first start bit
                        state    <= TX_START;
                    end
                end
                TX_START: begin
                    if (end_bit) begin
                        bit_idx <= '0;
                        uart_tx <= word_q[0];
                        state   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (end_bit) begin
                        if (bit_idx == bit_w'(BYTE_BITS - 1)) begin
                            uart_tx <= 1'b1;
                            state   <= TX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            uart_tx <= word_q[0];
                        end
                    end
                end
                TX_STOP: begin
                    if (end_bit) state <= TX_GAP;
                end
                TX_GAP: begin
                    if (end_bit) begin
                        if (byte_idx == byte_w'(WORD_BYTES - 1)) begin
                            state <= TX_IDLE;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                            uart_tx  <= 1'b0;
                            state    <= TX_START;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // shifted once per data bit, next byte lands at the bottom
    always_ff @(posedge CLK_I) begin
        if (restart) begin
            word_q <= tx_word;
        end else if (end_bit && (state == TX_START ||
                     (state == TX_DATA && bit_idx != bit_w'(BYTE_BITS - 1)))) begin
            word_q <= {1'b0, word_q[WORD_BYTES*BYTE_BITS-1:1]};
        end
    end

endmodule

// File: hw/fp32_uart_echo.sv
`timescale 1ns/1ps

module fp32_uart_echo import uart_pkg::*; #(
    parameter int clks_per_bit = DEFAULT_CLKS_PER_BIT
) (
    input  logic                             CLK_I,
    input  logic                             RSTL_I,
    input  logic                             uart_rx,
    output logic                             uart_tx,
    output logic                             rx_frame_valid,
    output logic [FRAME_BYTES*BYTE_BITS-1:0] rx_frame
);

    logic  byte_valid;
    byte_t rx_byte;

    uart_byte_rx #(
        .clks_per_bit(clks_per_bit)
    ) i_uart_byte_rx (
        .CLK_I      (CLK_I),
        .RSTL_I     (RSTL_I),
        .uart_rx    (uart_rx),
        .byte_valid (byte_valid),
        .rx_byte    (rx_byte)
    );

    frame_assembler i_frame_assembler (
        .CLK_I       (CLK_I),
        .RSTL_I      (RSTL_I),
        .byte_valid  (byte_valid),
        .rx_byte     (rx_byte),
        .frame_valid (rx_frame_valid),
        .frame       (rx_frame)
    );

    // operand A goes back out
    uart_word_tx #(
        .clks_per_bit(clks_per_bit)
    ) i_uart_word_tx (
        .CLK_I       (CLK_I),
        .RSTL_I      (RSTL_I),
        .frame_valid (rx_frame_valid),
        .tx_word     (rx_frame[WORD_BYTES*BYTE_BITS-1:0]),
        .uart_tx     (uart_tx)
    );

endmodule

// File: dv/fp32_uart_echo_props.sv
`timescale 1ns/1ps

module fp32_uart_echo_props import uart_pkg::*; (
    input logic                             CLK_I,
    input logic                             RSTL_I,
    input logic                             uart_tx,
    input logic                             rx_frame_valid,
    input logic [FRAME_BYTES*BYTE_BITS-1:0] rx_frame
);

    logic seen_valid; // set by the first frame pulse

    always_ff @(posedge CLK_I or negedge RSTL_I) begin
        if (!RSTL_I) begin
            seen_valid <= 1'b0;
        end else if (rx_frame_valid) begin
            seen_valid <= 1'b1;
        end
    end

    // valid is a single-cycle strobe
    valid_one_cycle: assert property (
        @(posedge CLK_I) disable iff (!RSTL_I)
        rx_frame_valid |=> !rx_frame_valid
    ) else $error("rx_frame_valid high on two consecutive cycles");

    frame_only_on_valid: assert property (
        @(posedge CLK_I) disable iff (!RSTL_I)
        !$stable(rx_frame) |-> rx_frame_valid
    ) else $error("rx_frame changed without rx_frame_valid");

    // no echo can start before a frame exists
    tx_idle_until_frame: assert property (
        @(posedge CLK_I) disable iff (!RSTL_I)
        !seen_valid |-> uart_tx
    ) else $error("uart_tx left idle before the first frame");

endmodule

bind fp32_uart_echo fp32_uart_echo_props i_fp32_uart_echo_props (.*);

// File: dv/tb_fp32_uart_echo.sv
`timescale 1ns/1ps

module tb_fp32_uart_echo import uart_pkg::*; ();

    localparam int clk_ns      = 40;
    localparam int bit_clks    = 16;
    localparam int num_frames  = 3;
    localparam int frame_ns    = num_frames * FRAME_BYTES * 10 * bit_clks * clk_ns;
    localparam int echo_ns     = WORD_BYTES * 11 * bit_clks * clk_ns;
    localparam int watchdog_ns = 2 * (frame_ns + echo_ns);
    localparam int echo_bytes  = num_frames * WORD_BYTES;

    logic   CLK_I;
    logic   RSTL_I;
    logic   uart_rx;
    logic   uart_tx;
    logic   rx_frame_valid;
    frame_t rx_frame;

    int          mismatch_count = 0;
    int          fail_count     = 0;
    int          valid_count    = 0;
    int          echo_count     = 0;
    logic [31:0] lcg_state;
    frame_t      exp_frames[$];
    byte_t       exp_echo[$];

    fp32_uart_echo #(
        .clks_per_bit(bit_clks)
    ) i_fp32_uart_echo (
        .CLK_I          (CLK_I),
        .RSTL_I         (RSTL_I),
        .uart_rx        (uart_rx),
        .uart_tx        (uart_tx),
        .rx_frame_valid (rx_frame_valid),
        .rx_frame       (rx_frame)
    );

    initial begin
        CLK_I = 1'b0;
        forever #(clk_ns / 2) CLK_I = ~CLK_I;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic send_byte(input byte_t b);
        uart_rx = 1'b0; // start bit
        repeat (bit_clks) @(negedge CLK_I);
        for (int i = 0; i < BYTE_BITS; i++) begin
            uart_rx = b[i];
            repeat (bit_clks) @(negedge CLK_I);
        end
        uart_rx = 1'b1;
        repeat (bit_clks) @(negedge CLK_I);
    endtask

    // expectations are queued before the frame goes out
    task automatic send_frame();
        frame_t f;
        byte_t  bytes [FRAME_BYTES];
        f = '0;
        for (int i = 0; i < FRAME_BYTES; i++) begin
            lcg_state = lcg_next(lcg_state);
            bytes[i] = lcg_state[31:24]; // upper bits are the better ones
            f[i*BYTE_BITS +: BYTE_BITS] = bytes[i];
        end
        exp_frames.push_back(f);
        for (int i = 0; i < WORD_BYTES; i++) exp_echo.push_back(bytes[i]);
        for (int i = 0; i < FRAME_BYTES; i++) send_byte(bytes[i]);
    endtask

    always @(negedge CLK_I) begin : frame_monitor
        frame_t exp;
        if (RSTL_I && rx_frame_valid) begin
            valid_count++;
            if (exp_frames.size() == 0) begin
                fail_count++;
                $display("%0t: frame valid pulse without a frame being sent", $time);
            end else begin
                exp = exp_frames.pop_front();
                assert (rx_frame === exp) else begin
                    mismatch_count++;
                    $display("MISMATCH %0t: frame %0d is %h, expected %h",
                             $time, valid_count, rx_frame, exp);
                end
            end
        end
    end

    initial begin : echo_decoder
        byte_t b;
        byte_t exp;
        logic  stop_bit;
        @(posedge RSTL_I);
        forever begin
            @(negedge CLK_I);
            if (uart_tx == 1'b0) begin
                repeat (bit_clks / 2) @(negedge CLK_I); // middle of start bit
                for (int i = 0; i < BYTE_BITS; i++) begin
                    repeat (bit_clks) @(negedge CLK_I);
                    b[i] = uart_tx;
                end
                repeat (bit_clks) @(negedge CLK_I);
                stop_bit = uart_tx;
                echo_count++;
                if (exp_echo.size() == 0) begin
                    fail_count++;
                    $display("%0t: echo byte %02h arrived with no frame pending", $time, b);
                end else begin
                    exp = exp_echo.pop_front();
                    assert (b === exp) else begin
                        mismatch_count++;
                        $display("MISMATCH %0t: echo byte %0d is %02h, expected %02h",
                                 $time, echo_count, b, exp);
                    end
                end
                assert (stop_bit === 1'b1) else begin
                    mismatch_count++;
                    $display("MISMATCH %0t: echo byte %0d has a low stop bit",
                             $time, echo_count);
                end
            end
        end
    end

    initial begin : stimulus
        int wait_cycles;
        uart_rx   = 1'b1;
        RSTL_I    = 1'b0;
        lcg_state = 32'h3ca0b00b;
        repeat (8) @(negedge CLK_I);
        RSTL_I = 1'b1;
        repeat (20) begin
            @(negedge CLK_I);
            assert (uart_tx === 1'b1 && rx_frame_valid === 1'b0 && rx_frame === '0) else begin
                mismatch_count++;
                $display("MISMATCH %0t: outputs not at reset values", $time);
            end
        end
        // low pulse well under half a bit
        uart_rx = 1'b0;
        repeat (4) @(negedge CLK_I);
        uart_rx = 1'b1;
        repeat (2 * bit_clks) @(negedge CLK_I);
        repeat (num_frames) send_frame(); // back to back
        wait_cycles = 0;
        while (echo_count < echo_bytes && wait_cycles < 2 * echo_ns / clk_ns) begin
            @(negedge CLK_I);
            wait_cycles++;
        end
        if (echo_count < echo_bytes) begin
            fail_count++;
            $display("echo incomplete, only %0d of %0d bytes came back", echo_count, echo_bytes);
        end
        repeat (4 * bit_clks) @(negedge CLK_I); // catch stray pulses
        assert (valid_count == num_frames && echo_count == echo_bytes) else begin
            mismatch_count++;
            $display("MISMATCH %0t: saw %0d frames and %0d echo bytes, expected %0d and %0d",
                     $time, valid_count, echo_count, num_frames, echo_bytes);
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the run did not finish", watchdog_ns);
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count + 1);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: fp32_uart_echo.f
hw/uart_pkg.sv
hw/baud_timer.sv
hw/uart_byte_rx.sv
hw/frame_assembler.sv
hw/uart_word_tx.sv
hw/fp32_uart_echo.sv
dv/fp32_uart_echo_props.sv
dv/tb_fp32_uart_echo.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the fp32_uart_echo testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tb_fp32_uart_echo \
    -f fp32_uart_echo.f -o tb_fp32_uart_echo > build.log 2>&1 \
    || { echo "verilator build failed, see build.log"; exit 1; }
# a simulator stop on an assertion counts as a failed run
./obj_dir/tb_fp32_uart_echo > sim.log 2>&1 \
    || echo "** FAIL **" >> sim.log
cat sim.log
grep -qF "** FAIL **" sim.log && { echo "simulation failed"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
